// ==== source/soc_defines.svh ====
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// ==============================
// Bus widths
// ==============================
`define SOC_ADDR_W 32 // Byte address width on every AXI-Lite bundle.
`define SOC_DATA_W 32
`define SOC_STRB_W 4 // One strobe bit per data byte.

// ==============================
// Memory map
// ==============================
`define SOC_SRAM_BASE 32'h8000_0000 // First byte of the on-chip SRAM.
`define SOC_SRAM_WORDS 256 // Depth in 32-bit words, so the window is 1 KiB.
`define SOC_UART_ADDR 32'h1000_0000 // UART transmit register, write only.

`endif

// ==== source/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

	// AXI response codes. Only the two that this bus ever returns are named.
	typedef enum logic [1:0] {
		OKAY   = 2'd0, // Normal completion.
		DECERR = 2'd3  // No slave decodes the address.
	} axi_resp_t;

	// Crossbar routing state.
	// The crossbar keeps one transaction in flight, and the route says which
	// slave owns the bus until the response handshake.
	typedef enum logic [1:0] {
		ROUTE_IDLE = 2'd0, // Waiting for a request to decode.
		ROUTE_SRAM = 2'd1, // SRAM owns the bus.
		ROUTE_UART = 2'd2, // UART transmit register owns the write channels.
		ROUTE_ERR  = 2'd3  // Crossbar answers with DECERR itself.
	} xbar_route_t;

endpackage

`default_nettype wire

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module bus_arbiter (
	input  logic clk,
	input  logic rst,
	// Instruction fetch master, read channels only.
	input  logic [`SOC_ADDR_W-1:0] fetch_araddr,
	input  logic fetch_arvalid, fetch_rready,
	output logic fetch_arready, fetch_rvalid,
	output logic [`SOC_DATA_W-1:0] fetch_rdata,
	output axil_pkg::axi_resp_t fetch_rresp,
	// Load/store master, full AXI-Lite.
	input  logic [`SOC_ADDR_W-1:0] data_araddr, data_awaddr,
	input  logic data_arvalid, data_rready, data_awvalid, data_wvalid, data_bready,
	input  logic [`SOC_DATA_W-1:0] data_wdata,
	input  logic [`SOC_STRB_W-1:0] data_wstrb,
	output logic data_arready, data_rvalid, data_awready, data_wready, data_bvalid,
	output logic [`SOC_DATA_W-1:0] data_rdata,
	output axil_pkg::axi_resp_t data_rresp, data_bresp,
	// Shared bus toward the crossbar.
	output logic [`SOC_ADDR_W-1:0] bus_araddr, bus_awaddr,
	output logic bus_arvalid, bus_rready, bus_awvalid, bus_wvalid, bus_bready,
	output logic [`SOC_DATA_W-1:0] bus_wdata,
	output logic [`SOC_STRB_W-1:0] bus_wstrb,
	input  logic bus_arready, bus_rvalid, bus_awready, bus_wready, bus_bvalid,
	input  logic [`SOC_DATA_W-1:0] bus_rdata,
	input  axil_pkg::axi_resp_t bus_rresp, bus_bresp
);

	import axil_pkg::*;

	logic gnt_fetch_q; // Fetch master owns the bus.
	logic gnt_data_q; // Load/store master owns the bus.
	logic last_data_q; // The previous grant went to the load/store master.
	logic fetch_req;
	logic data_req;
	logic win_data; // Load/store wins the next free-bus decision.
	logic done; // Response handshake of the owner.

	// A write only counts as a request once address and data are both valid.
	assign fetch_req = fetch_arvalid;
	assign data_req = data_arvalid | (data_awvalid & data_wvalid);
	// On a tie the master that did not have the last grant goes first.
	assign win_data = (fetch_req && data_req) ? !last_data_q : data_req;

	assign done = (fetch_rvalid & fetch_rready) | (data_rvalid & data_rready) |
		(data_bvalid & data_bready);

	// ==============================
	// Grant register
	// ==============================
	always_ff @(posedge clk) begin
		if (!rst) begin
			gnt_fetch_q <= 1'b0;
			gnt_data_q <= 1'b0;
			last_data_q <= 1'b1; // Fetch wins the first tie after reset.
		end else if (!(gnt_fetch_q || gnt_data_q)) begin
			gnt_fetch_q <= fetch_req & !win_data;
			gnt_data_q <= win_data; // Stays low when nobody asks.
			if (fetch_req || data_req) begin
				last_data_q <= win_data;
			end
		end else if (done) begin
			gnt_fetch_q <= 1'b0; // Bus is free again on the next cycle.
			gnt_data_q <= 1'b0;
		end
	end

	// ==============================
	// Request and response steering
	// ==============================
	// Addresses and write payload pass through; only valid and ready are gated.
	assign bus_araddr = gnt_data_q ? data_araddr : fetch_araddr;
	assign bus_arvalid = (gnt_fetch_q & fetch_arvalid) | (gnt_data_q & data_arvalid);
	assign bus_rready = (gnt_fetch_q & fetch_rready) | (gnt_data_q & data_rready);
	assign bus_awaddr = data_awaddr; // Only the load/store master writes.
	assign bus_awvalid = gnt_data_q & data_awvalid;
	assign bus_wdata = data_wdata;
	assign bus_wstrb = data_wstrb;
	assign bus_wvalid = gnt_data_q & data_wvalid;
	assign bus_bready = gnt_data_q & data_bready;

	// The master without the grant sees every ready and valid low.
	assign fetch_arready = gnt_fetch_q & bus_arready;
	assign fetch_rvalid = gnt_fetch_q & bus_rvalid;
	assign fetch_rdata = bus_rdata;
	assign fetch_rresp = gnt_fetch_q ? bus_rresp : OKAY;

	assign data_arready = gnt_data_q & bus_arready;
	assign data_rvalid = gnt_data_q & bus_rvalid;
	assign data_rdata = bus_rdata;
	assign data_rresp = gnt_data_q ? bus_rresp : OKAY;
	assign data_awready = gnt_data_q & bus_awready;
	assign data_wready = gnt_data_q & bus_wready;
	assign data_bvalid = gnt_data_q & bus_bvalid;
	assign data_bresp = gnt_data_q ? bus_bresp : OKAY;

endmodule

`default_nettype wire

// ==== source/axil_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module axil_xbar (
	input  logic clk,
	input  logic rst,
	// Master side, from the arbiter.
	input  logic [`SOC_ADDR_W-1:0] bus_araddr, bus_awaddr,
	input  logic bus_arvalid, bus_rready, bus_awvalid, bus_wvalid, bus_bready,
	input  logic [`SOC_DATA_W-1:0] bus_wdata,
	input  logic [`SOC_STRB_W-1:0] bus_wstrb,
	output logic bus_arready, bus_rvalid, bus_awready, bus_wready, bus_bvalid,
	output logic [`SOC_DATA_W-1:0] bus_rdata,
	output axil_pkg::axi_resp_t bus_rresp, bus_bresp,
	// SRAM slave.
	output logic [`SOC_ADDR_W-1:0] sram_araddr, sram_awaddr,
	output logic sram_arvalid, sram_rready, sram_awvalid, sram_wvalid, sram_bready,
	output logic [`SOC_DATA_W-1:0] sram_wdata,
	output logic [`SOC_STRB_W-1:0] sram_wstrb,
	input  logic sram_arready, sram_rvalid, sram_awready, sram_wready, sram_bvalid,
	input  logic [`SOC_DATA_W-1:0] sram_rdata,
	input  axil_pkg::axi_resp_t sram_rresp, sram_bresp,
	// UART slave, write channels only.
	output logic uart_awvalid, uart_wvalid, uart_bready,
	output logic [`SOC_DATA_W-1:0] uart_wdata,
	output logic [`SOC_STRB_W-1:0] uart_wstrb,
	input  logic uart_awready, uart_wready, uart_bvalid,
	input  axil_pkg::axi_resp_t uart_bresp
);

	import axil_pkg::*;

	localparam logic [`SOC_ADDR_W-1:0] SRAM_BYTES = `SOC_SRAM_WORDS * 4;

	xbar_route_t route_q;
	logic rd_q; // The routed transaction is a read.
	logic err_resp_q; // DECERR response is being presented.
	logic ar_sram, aw_sram, aw_uart;
	logic wr_req;
	logic done;

	// Window test by offset, so one unsigned compare covers both bounds.
	assign ar_sram = (bus_araddr - `SOC_SRAM_BASE) < SRAM_BYTES;
	assign aw_sram = (bus_awaddr - `SOC_SRAM_BASE) < SRAM_BYTES;
	assign aw_uart = bus_awaddr == `SOC_UART_ADDR;
	assign wr_req = bus_awvalid & bus_wvalid;
	// The route ends on the response handshake of its own direction.
	assign done = rd_q ? (bus_rvalid & bus_rready) : (bus_bvalid & bus_bready);

	// ==============================
	// Routing FSM
	// ==============================
	always_ff @(posedge clk) begin
		if (!rst) begin
			route_q <= ROUTE_IDLE;
			rd_q <= 1'b0;
			err_resp_q <= 1'b0;
		end else begin
			case (route_q)
				ROUTE_IDLE: begin
					if (bus_arvalid) begin // Reads are decoded first.
						rd_q <= 1'b1;
						route_q <= ar_sram ? ROUTE_SRAM : ROUTE_ERR; // UART reads fail too.
					end else if (wr_req) begin
						rd_q <= 1'b0;
						if (aw_uart) begin
							route_q <= ROUTE_UART;
						end else begin
							route_q <= aw_sram ? ROUTE_SRAM : ROUTE_ERR;
						end
					end
				end
				ROUTE_ERR: begin
					if (done) begin
						route_q <= ROUTE_IDLE;
						err_resp_q <= 1'b0;
					end else begin
						err_resp_q <= 1'b1; // Request was taken in the first routed cycle.
					end
				end
				default: begin
					if (done) begin
						route_q <= ROUTE_IDLE;
					end
				end
			endcase
		end
	end

	// Payloads go to both slaves; only the valid signals select one.
	assign sram_araddr = bus_araddr;
	assign sram_awaddr = bus_awaddr;
	assign sram_wdata = bus_wdata;
	assign sram_wstrb = bus_wstrb;
	assign uart_wdata = bus_wdata;
	assign uart_wstrb = bus_wstrb;

	// ==============================
	// Channel steering
	// ==============================
	always_comb begin
		bus_arready = 1'b0; // Nothing is connected unless a route says so.
		bus_rvalid = 1'b0;
		bus_rdata = '0;
		bus_rresp = OKAY;
		bus_awready = 1'b0;
		bus_wready = 1'b0;
		bus_bvalid = 1'b0;
		bus_bresp = OKAY;
		sram_arvalid = 1'b0;
		sram_rready = 1'b0;
		sram_awvalid = 1'b0;
		sram_wvalid = 1'b0;
		sram_bready = 1'b0;
		uart_awvalid = 1'b0;
		uart_wvalid = 1'b0;
		uart_bready = 1'b0;
		case (route_q)
			ROUTE_SRAM: begin
				if (rd_q) begin
					sram_arvalid = bus_arvalid;
					sram_rready = bus_rready;
					bus_arready = sram_arready;
					bus_rvalid = sram_rvalid;
					bus_rdata = sram_rdata;
					bus_rresp = sram_rresp;
				end else begin
					sram_awvalid = bus_awvalid;
					sram_wvalid = bus_wvalid;
					sram_bready = bus_bready;
					bus_awready = sram_awready;
					bus_wready = sram_wready;
					bus_bvalid = sram_bvalid;
					bus_bresp = sram_bresp;
				end
			end
			ROUTE_UART: begin
				uart_awvalid = bus_awvalid;
				uart_wvalid = bus_wvalid;
				uart_bready = bus_bready;
				bus_awready = uart_awready;
				bus_wready = uart_wready;
				bus_bvalid = uart_bvalid;
				bus_bresp = uart_bresp;
			end
			ROUTE_ERR: begin
				bus_arready = rd_q & !err_resp_q; // Accept, then answer a cycle later.
				bus_awready = !rd_q & !err_resp_q;
				bus_wready = !rd_q & !err_resp_q;
				bus_rvalid = rd_q & err_resp_q;
				bus_rresp = DECERR; // Read data stays zero.
				bus_bvalid = !rd_q & err_resp_q;
				bus_bresp = DECERR;
			end
			default: begin
				// Idle, so the defaults above hold.
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/sram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module sram_slave (
	input  logic clk,
	input  logic rst,
	// Read channels.
	input  logic [`SOC_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [`SOC_DATA_W-1:0] rdata,
	output axil_pkg::axi_resp_t rresp,
	output logic rvalid,
	input  logic rready,
	// Write channels.
	input  logic [`SOC_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [`SOC_DATA_W-1:0] wdata,
	input  logic [`SOC_STRB_W-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output axil_pkg::axi_resp_t bresp,
	output logic bvalid,
	input  logic bready
);

	import axil_pkg::*;

	localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);

	logic [`SOC_DATA_W-1:0] mem [`SOC_SRAM_WORDS];
	logic [`SOC_ADDR_W-1:0] rd_off, wr_off; // Byte offsets into the window.
	logic busy; // A response is being held.
	logic ar_fire, wr_fire;

	assign rd_off = araddr - `SOC_SRAM_BASE;
	assign wr_off = awaddr - `SOC_SRAM_BASE;

	assign busy = rvalid | bvalid;
	assign arready = !busy;
	assign awready = !busy;
	assign wready = !busy;
	assign ar_fire = arvalid & arready;
	assign wr_fire = awvalid & awready & wvalid & wready; // Address and data move together.

	// Every address that reaches this slave was already decoded inside the window.
	assign rresp = OKAY;
	assign bresp = OKAY;

	// ==============================
	// Storage
	// ==============================
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rdata <= mem[rd_off[IDX_W+1:2]]; // Word index sits above the byte lanes.
		end
		if (wr_fire) begin
			for (int b = 0; b < `SOC_STRB_W; b++) begin
				if (wstrb[b]) begin
					mem[wr_off[IDX_W+1:2]][8*b +: 8] <= wdata[8*b +: 8]; // Strobed bytes only.
				end
			end
		end
	end

	// Response valid rises one cycle after acceptance and holds until taken.
	always_ff @(posedge clk) begin
		if (!rst) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (ar_fire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			if (wr_fire) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/uart_tx_slave.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module uart_tx_slave (
	input  logic clk,
	input  logic rst,
	// Write channels; the crossbar has already matched the address.
	input  logic awvalid,
	output logic awready,
	input  logic [`SOC_DATA_W-1:0] wdata,
	input  logic [`SOC_STRB_W-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output axil_pkg::axi_resp_t bresp,
	output logic bvalid,
	input  logic bready,
	// Transmit byte, valid for a single cycle.
	output logic [7:0] tx_data,
	output logic tx_valid
);

	import axil_pkg::*;

	logic wr_fire;

	assign awready = !bvalid; // Ready again once the response is gone.
	assign wready = !bvalid;
	assign wr_fire = awvalid & awready & wvalid & wready;
	assign bresp = OKAY; // Even a write that sends nothing completes normally.

	// Only the low byte lane carries a character.
	always_ff @(posedge clk) begin
		if (wr_fire && wstrb[0]) begin
			tx_data <= wdata[7:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			tx_valid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			tx_valid <= wr_fire & wstrb[0]; // Pulse, in step with bvalid rising.
			if (wr_fire) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/soc_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module soc_bus_top (
	input  logic clk,
	input  logic rst,
	// Instruction fetch master.
	input  logic [`SOC_ADDR_W-1:0] fetch_araddr,
	input  logic fetch_arvalid, fetch_rready,
	output logic fetch_arready, fetch_rvalid,
	output logic [`SOC_DATA_W-1:0] fetch_rdata,
	output axil_pkg::axi_resp_t fetch_rresp,
	// Load/store master.
	input  logic [`SOC_ADDR_W-1:0] data_araddr, data_awaddr,
	input  logic data_arvalid, data_rready, data_awvalid, data_wvalid, data_bready,
	input  logic [`SOC_DATA_W-1:0] data_wdata,
	input  logic [`SOC_STRB_W-1:0] data_wstrb,
	output logic data_arready, data_rvalid, data_awready, data_wready, data_bvalid,
	output logic [`SOC_DATA_W-1:0] data_rdata,
	output axil_pkg::axi_resp_t data_rresp, data_bresp,
	// UART transmit byte.
	output logic [7:0] tx_data,
	output logic tx_valid
);

	import axil_pkg::*;

	// Arbiter to crossbar.
	logic [`SOC_ADDR_W-1:0] bus_araddr, bus_awaddr;
	logic bus_arvalid, bus_rready, bus_awvalid, bus_wvalid, bus_bready;
	logic [`SOC_DATA_W-1:0] bus_wdata, bus_rdata;
	logic [`SOC_STRB_W-1:0] bus_wstrb;
	logic bus_arready, bus_rvalid, bus_awready, bus_wready, bus_bvalid;
	axi_resp_t bus_rresp, bus_bresp;
	// Crossbar to SRAM.
	logic [`SOC_ADDR_W-1:0] sram_araddr, sram_awaddr;
	logic sram_arvalid, sram_rready, sram_awvalid, sram_wvalid, sram_bready;
	logic [`SOC_DATA_W-1:0] sram_wdata, sram_rdata;
	logic [`SOC_STRB_W-1:0] sram_wstrb;
	logic sram_arready, sram_rvalid, sram_awready, sram_wready, sram_bvalid;
	axi_resp_t sram_rresp, sram_bresp;
	// Crossbar to UART.
	logic uart_awvalid, uart_wvalid, uart_bready, uart_awready, uart_wready, uart_bvalid;
	logic [`SOC_DATA_W-1:0] uart_wdata;
	logic [`SOC_STRB_W-1:0] uart_wstrb;
	axi_resp_t uart_bresp;

	// Port names already match the bundles above.
	bus_arbiter bus_arbiter_inst (.*);

	axil_xbar axil_xbar_inst (.*);

	sram_slave sram_slave_inst (
		.clk(clk), .rst(rst),
		.araddr(sram_araddr), .arvalid(sram_arvalid), .arready(sram_arready),
		.rdata(sram_rdata), .rresp(sram_rresp), .rvalid(sram_rvalid), .rready(sram_rready),
		.awaddr(sram_awaddr), .awvalid(sram_awvalid), .awready(sram_awready),
		.wdata(sram_wdata), .wstrb(sram_wstrb), .wvalid(sram_wvalid), .wready(sram_wready),
		.bresp(sram_bresp), .bvalid(sram_bvalid), .bready(sram_bready)
	);

	uart_tx_slave uart_tx_slave_inst (
		.clk(clk), .rst(rst),
		.awvalid(uart_awvalid), .awready(uart_awready),
		.wdata(uart_wdata), .wstrb(uart_wstrb), .wvalid(uart_wvalid), .wready(uart_wready),
		.bresp(uart_bresp), .bvalid(uart_bvalid), .bready(uart_bready),
		.tx_data(tx_data), .tx_valid(tx_valid)
	);

endmodule

`default_nettype wire

// ==== sim/tb_soc_bus.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module tb_soc_bus;

	import axil_pkg::*;

	localparam int TXN_CYCLES = 20; // Longest wait allowed for one handshake.
	localparam int MAX_CYCLES = 6 * 16 * TXN_CYCLES + 80; // Six tests of about 16 transactions.
	localparam int NUM_WORDS = 5; // SRAM words touched by the first test.
	localparam logic [31:0] WINDOW_END = `SOC_SRAM_BASE + `SOC_SRAM_WORDS * 4;

	logic clk, rst;
	logic [31:0] fetch_araddr, fetch_rdata;
	logic fetch_arvalid, fetch_rready, fetch_arready, fetch_rvalid;
	axi_resp_t fetch_rresp;
	logic [31:0] data_araddr, data_awaddr, data_wdata, data_rdata;
	logic [3:0] data_wstrb;
	logic data_arvalid, data_rready, data_awvalid, data_wvalid, data_bready;
	logic data_arready, data_rvalid, data_awready, data_wready, data_bvalid;
	axi_resp_t data_rresp, data_bresp;
	logic [7:0] tx_data;
	logic tx_valid;

	logic [31:0] lfsr; // Galois LFSR state.
	logic [31:0] shadow [`SOC_SRAM_WORDS]; // Expected SRAM contents.
	logic [7:0] word_idx [NUM_WORDS];
	logic [7:0] tx_last; // Last byte seen on the UART output.
	logic last_owner_data; // Which master finished the previous transaction.
	int tx_count, cycles, checks, errors, errors_at_start, test_num;
	logic [31:0] val, f_val, d_val;
	logic [3:0] strb;
	axi_resp_t resp, f_resp, d_resp;
	int stall, count_before, seq, f_done, d_done;
	logic expect_fetch_first;

	soc_bus_top soc_bus_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period.
	end

	// ==============================
	// Helpers
	// ==============================
	// One LFSR step per bit taken, oldest bit ends up in the MSB.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return bits;
	endfunction

	function automatic logic [31:0] sram_addr(input logic [7:0] idx);
		return `SOC_SRAM_BASE + {22'd0, idx, 2'b00};
	endfunction

	// Byte lanes with a strobe take the new data; the rest keep the old word.
	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
			input logic [31:0] data, input logic [3:0] lanes);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (lanes[b]) begin
				res[8*b +: 8] = data[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t ns: %s got 0x%08h expected 0x%08h",
				$time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic finish_test(input string name);
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	// ==============================
	// Bus tasks
	// ==============================
	// Inputs change 1 ns after a rising edge, outputs are sampled at the falling edge.
	task automatic write_data(input logic [31:0] a, input logic [31:0] d,
			input logic [3:0] s, output axi_resp_t r);
		int n;
		logic ok;
		r = OKAY;
		data_awaddr = a;
		data_wdata = d;
		data_wstrb = s;
		data_awvalid = 1'b1; // Address and data are raised together.
		data_wvalid = 1'b1;
		data_bready = 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!(data_awready && data_wready) && n < TXN_CYCLES);
		ok = data_awready && data_wready;
		@(posedge clk);
		#1;
		data_awvalid = 1'b0;
		data_wvalid = 1'b0;
		if (!ok) begin
			report_problem("data write address and data were never accepted");
		end else begin
			n = 0;
			do begin
				@(negedge clk);
				n++;
			end while (!data_bvalid && n < TXN_CYCLES);
			ok = data_bvalid;
			r = data_bresp;
			@(posedge clk);
			#1;
			if (!ok) begin
				report_problem("data write response never arrived");
			end
		end
		data_bready = 1'b0;
		last_owner_data = 1'b1;
	endtask

	// A nonzero stall keeps rready low for that many cycles after rvalid rises.
	task automatic read_data(input logic [31:0] a, input int hold,
			output logic [31:0] d, output axi_resp_t r);
		int n;
		logic ok;
		d = '0;
		r = OKAY;
		data_araddr = a;
		data_arvalid = 1'b1;
		data_rready = (hold == 0);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!data_arready && n < TXN_CYCLES);
		ok = data_arready;
		@(posedge clk);
		#1;
		data_arvalid = 1'b0;
		if (!ok) begin
			report_problem("data read address was never accepted");
		end else begin
			n = 0;
			do begin
				@(negedge clk);
				n++;
			end while (!data_rvalid && n < TXN_CYCLES);
			ok = data_rvalid;
			d = data_rdata;
			r = data_rresp;
			if (!ok) begin
				report_problem("data read response never arrived");
			end else begin
				for (int i = 0; i < hold; i++) begin
					@(posedge clk);
					#1;
					data_rready = (i == hold - 1); // Taken on the edge after the last stall.
					@(negedge clk);
					check_value("data_rvalid", 32'(data_rvalid), 32'd1);
					check_value("data_rdata", data_rdata, d);
				end
				@(posedge clk);
				#1;
			end
		end
		data_rready = 1'b0;
		last_owner_data = 1'b1;
	endtask

	// Same stall rule as the data read, the hold assertion watches the response.
	task automatic read_fetch(input logic [31:0] a, input int hold,
			output logic [31:0] d, output axi_resp_t r);
		int n;
		logic ok;
		d = '0;
		r = OKAY;
		fetch_araddr = a;
		fetch_arvalid = 1'b1;
		fetch_rready = (hold == 0);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!fetch_arready && n < TXN_CYCLES);
		ok = fetch_arready;
		@(posedge clk);
		#1;
		fetch_arvalid = 1'b0;
		if (!ok) begin
			report_problem("fetch read address was never accepted");
		end else begin
			n = 0;
			do begin
				@(negedge clk);
				n++;
			end while (!fetch_rvalid && n < TXN_CYCLES);
			ok = fetch_rvalid;
			d = fetch_rdata;
			r = fetch_rresp;
			if (!ok) begin
				report_problem("fetch read response never arrived");
			end else begin
				for (int i = 0; i < hold; i++) begin
					@(posedge clk);
					#1;
					fetch_rready = (i == hold - 1);
				end
				@(posedge clk);
				#1;
			end
		end
		fetch_rready = 1'b0;
		last_owner_data = 1'b0;
	endtask

	// ==============================
	// Monitors and limits
	// ==============================
	always @(negedge clk) begin
		if (rst && tx_valid) begin
			tx_count++; // Counts UART pulses.
			tx_last = tx_data;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	rvalid_hold_fetch: assert property (@(posedge clk) disable iff (!rst)
		fetch_rvalid && !fetch_rready |=> fetch_rvalid && $stable(fetch_rdata))
		else begin
			$display("ERROR at %0t ns: fetch read response changed before fetch_rready", $time);
			errors++;
		end

	rvalid_hold_data: assert property (@(posedge clk) disable iff (!rst)
		data_rvalid && !data_rready |=> data_rvalid && $stable(data_rdata))
		else begin
			$display("ERROR at %0t ns: data read response changed before data_rready", $time);
			errors++;
		end

	tx_single_cycle: assert property (@(posedge clk) disable iff (!rst) tx_valid |=> !tx_valid)
		else begin
			$display("ERROR at %0t ns: tx_valid stayed high for more than one cycle", $time);
			errors++;
		end

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		lfsr = 32'h50cc_849b;
		rst = 1'b0;
		fetch_araddr = '0;
		fetch_arvalid = 1'b0;
		fetch_rready = 1'b0;
		data_araddr = '0;
		data_awaddr = '0;
		data_wdata = '0;
		data_wstrb = '0;
		data_arvalid = 1'b0;
		data_rready = 1'b0;
		data_awvalid = 1'b0;
		data_wvalid = 1'b0;
		data_bready = 1'b0;
		last_owner_data = 1'b1;
		tx_count = 0;
		cycles = 0;
		checks = 0;
		errors = 0;
		errors_at_start = 0;
		test_num = 0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b1;

		// Full word first so every byte is known, then a random strobe on top.
		for (int i = 0; i < NUM_WORDS; i++) begin
			word_idx[i] = 8'(rand_bits(8));
			val = rand_bits(32);
			write_data(sram_addr(word_idx[i]), val, 4'hf, resp);
			check_value("data_bresp", 32'(resp), 32'(OKAY));
			shadow[word_idx[i]] = val;
			val = rand_bits(32);
			strb = 4'(rand_bits(4));
			write_data(sram_addr(word_idx[i]), val, strb, resp);
			check_value("data_bresp", 32'(resp), 32'(OKAY));
			shadow[word_idx[i]] = merge_bytes(shadow[word_idx[i]], val, strb);
		end
		for (int i = 0; i < NUM_WORDS; i++) begin
			read_data(sram_addr(word_idx[i]), 0, val, resp);
			check_value("data_rdata", val, shadow[word_idx[i]]);
			check_value("data_rresp", 32'(resp), 32'(OKAY));
		end
		finish_test("sram write and read-back");

		for (int i = 0; i < NUM_WORDS; i++) begin
			read_fetch(sram_addr(word_idx[i]), 0, val, resp);
			check_value("fetch_rdata", val, shadow[word_idx[i]]);
			check_value("fetch_rresp", 32'(resp), 32'(OKAY));
		end
		finish_test("fetch port reads");

		count_before = tx_count;
		val = rand_bits(32);
		write_data(`SOC_UART_ADDR, val, 4'(rand_bits(4)) | 4'b0001, resp);
		check_value("data_bresp", 32'(resp), 32'(OKAY));
		check_value("tx_valid pulses", 32'(tx_count - count_before), 32'd1);
		check_value("tx_data", 32'(tx_last), 32'(val[7:0]));
		count_before = tx_count;
		write_data(`SOC_UART_ADDR, rand_bits(32), 4'(rand_bits(4)) & 4'b1110, resp);
		check_value("data_bresp", 32'(resp), 32'(OKAY));
		check_value("tx_valid pulses", 32'(tx_count - count_before), 32'd0); // Lane 0 off.
		finish_test("uart transmit");

		read_data(32'h2000_0000, 0, val, resp);
		check_value("data_rresp", 32'(resp), 32'(DECERR));
		check_value("data_rdata", val, 32'd0);
		// One window past the first test word, so a wrapped index would hit it.
		write_data(WINDOW_END + {22'd0, word_idx[0], 2'b00}, rand_bits(32), 4'hf, resp);
		check_value("data_bresp", 32'(resp), 32'(DECERR));
		read_data(`SOC_UART_ADDR, 0, val, resp);
		check_value("data_rresp", 32'(resp), 32'(DECERR));
		check_value("data_rdata", val, 32'd0);
		read_data(sram_addr(word_idx[0]), 0, val, resp);
		check_value("data_rdata", val, shadow[word_idx[0]]);
		finish_test("decode errors");

		for (int round = 0; round < 2; round++) begin
			if (round == 1) begin
				// Leave the last grant with fetch, so the data master should win the tie.
				read_fetch(sram_addr(word_idx[4]), 0, val, resp);
				check_value("fetch_rdata", val, shadow[word_idx[4]]);
			end
			expect_fetch_first = last_owner_data; // Master without the last grant goes first.
			seq = 0;
			fork
				begin
					read_fetch(sram_addr(word_idx[1 + round]), 0, f_val, f_resp);
					f_done = seq;
					seq++;
				end
				begin
					read_data(sram_addr(word_idx[3 - round]), 0, d_val, d_resp);
					d_done = seq;
					seq++;
				end
			join
			check_value("fetch_rdata", f_val, shadow[word_idx[1 + round]]);
			check_value("fetch_rresp", 32'(f_resp), 32'(OKAY));
			check_value("data_rdata", d_val, shadow[word_idx[3 - round]]);
			check_value("data_rresp", 32'(d_resp), 32'(OKAY));
			checks++;
			assert ((f_done < d_done) == expect_fetch_first)
				else report_problem("masters finished a tied request in the wrong order");
		end
		finish_test("arbitration");

		for (int i = 0; i < 4; i++) begin
			stall = 1 + rand_bits(3); // One to eight cycles.
			read_data(sram_addr(word_idx[i]), stall, val, resp);
			check_value("data_rdata", val, shadow[word_idx[i]]);
			check_value("data_rresp", 32'(resp), 32'(OKAY));
		end
		stall = 1 + rand_bits(3);
		read_fetch(sram_addr(word_idx[4]), stall, val, resp);
		check_value("fetch_rdata", val, shadow[word_idx[4]]);
		check_value("fetch_rresp", 32'(resp), 32'(OKAY));
		finish_test("read back-pressure");

		$display("summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/axil_pkg.sv
source/bus_arbiter.sv
source/axil_xbar.sv
source/sram_slave.sv
source/uart_tx_slave.sv
source/soc_bus_top.sv
sim/tb_soc_bus.sv

// ==== Makefile ====
# Verilator build and run for the shared AXI-Lite bus testbench.
VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= STATUS: PASS

SOURCES := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the simulation output.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
